// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= wisc_core.f
TOP        ?= wisc_core_tb
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --timescale $(TIMESCALE)
SIM_FLAGS  ?= --binary --timescale $(TIMESCALE)
PASS_MSG   ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire isa_pkg::data_t    a,
	input  wire isa_pkg::data_t    b,
	input  wire pipe_pkg::alu_op_t op,
	input  wire logic              inv_a,
	input  wire logic              inv_b,
	input  wire logic              cin,
	output isa_pkg::data_t         y,
	output logic                   carry,
	output logic                   ofl,
	output logic                   zero,
	output logic                   neg
);

	localparam int msb = isa_pkg::data_w - 1;

	isa_pkg::data_t              a_eff;
	isa_pkg::data_t              b_eff;
	isa_pkg::data_t              sum;
	logic [isa_pkg::data_w:0]    sum_full;
	logic [2*isa_pkg::data_w-1:0] rot_l;
	logic [2*isa_pkg::data_w-1:0] rot_r;
	logic [3:0]                  amt;

	assign a_eff = inv_a ? ~a : a;
	assign b_eff = inv_b ? ~b : b;

	assign sum_full = {1'b0, a_eff} + {1'b0, b_eff} + {{isa_pkg::data_w{1'b0}}, cin};
	assign sum = sum_full[msb:0];

	// Flags always come from the adder
	assign carry = sum_full[isa_pkg::data_w];
	assign ofl = (a_eff[msb] == b_eff[msb]) && (sum[msb] != a_eff[msb]);
	assign zero = (sum == '0);
	assign neg = sum[msb];

	// Shift amount is the low four bits of B
	assign amt = b[3:0];

	// Rotates via a doubled word
	assign rot_l = {a, a} << amt;
	assign rot_r = {a, a} >> amt;

	always_comb begin
		case (op)
			pipe_pkg::alu_add:  y = sum;
			pipe_pkg::alu_xor:  y = a_eff ^ b_eff;
			pipe_pkg::alu_andn: y = a_eff & ~b_eff;
			pipe_pkg::alu_rol:  y = rot_l[2*isa_pkg::data_w-1:isa_pkg::data_w];
			pipe_pkg::alu_sll:  y = a << amt;
			pipe_pkg::alu_ror:  y = rot_r[msb:0];
			pipe_pkg::alu_srl:  y = a >> amt;
			default:            y = sum;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire isa_pkg::instr_u   instr,
	input  wire logic              instr_valid,
	output isa_pkg::reg_idx_t      rd_idx_a,
	output isa_pkg::reg_idx_t      rd_idx_b,
	input  wire isa_pkg::data_t    rd_data_a,
	input  wire isa_pkg::data_t    rd_data_b,
	output pipe_pkg::dec_exe_t     dec_exe
);

	isa_pkg::opcode_t   opcode;
	pipe_pkg::ctrl_t    ctrl;
	pipe_pkg::dec_exe_t dec_next;

	function automatic pipe_pkg::alu_op_t shift_op(input isa_pkg::funct_t sel);
		case (sel)
			isa_pkg::funct_rol: shift_op = pipe_pkg::alu_rol;
			isa_pkg::funct_sll: shift_op = pipe_pkg::alu_sll;
			isa_pkg::funct_ror: shift_op = pipe_pkg::alu_ror;
			default:            shift_op = pipe_pkg::alu_srl;
		endcase
	endfunction

	// SUB forms compute B - A as ~A + B + 1
	function automatic pipe_pkg::ctrl_t arith_ctrl(input pipe_pkg::ctrl_t base,
		input isa_pkg::funct_t sel);
		pipe_pkg::ctrl_t c;
		c = base;
		case (sel)
			isa_pkg::funct_add: c.alu_op = pipe_pkg::alu_add;
			isa_pkg::funct_sub: begin
				c.alu_op = pipe_pkg::alu_add;
				c.inv_a = 1'b1;
				c.cin = 1'b1;
			end
			isa_pkg::funct_xor: c.alu_op = pipe_pkg::alu_xor;
			default:            c.alu_op = pipe_pkg::alu_andn;
		endcase
		return c;
	endfunction

	assign opcode = instr.r_fmt.opcode;
	assign rd_idx_a = instr.r_fmt.rs;
	assign rd_idx_b = instr.r_fmt.rt;

	always_comb begin
		ctrl = '0;
		ctrl.reg_write = 1'b1;
		ctrl.alu_op = pipe_pkg::alu_add;
		ctrl.imm_sel = pipe_pkg::imm_none;
		ctrl.set_op = pipe_pkg::set_eq;
		ctrl.out_sel = isa_pkg::out_alu;
		ctrl.dst = instr.r_fmt.rd;

		case (opcode)
			isa_pkg::op_alu_r: ctrl = arith_ctrl(ctrl, instr.r_fmt.funct);
			isa_pkg::op_shift_r: ctrl.alu_op = shift_op(instr.r_fmt.funct);
			isa_pkg::op_addi, isa_pkg::op_subi: begin
				ctrl = arith_ctrl(ctrl, opcode[1:0]);
				ctrl.imm_sel = pipe_pkg::imm_sext5;
				ctrl.dst = instr.i1_fmt.rd;
			end
			isa_pkg::op_xori, isa_pkg::op_andni: begin
				ctrl = arith_ctrl(ctrl, opcode[1:0]);
				ctrl.imm_sel = pipe_pkg::imm_zext5;
				ctrl.dst = instr.i1_fmt.rd;
			end
			isa_pkg::op_roli, isa_pkg::op_slli, isa_pkg::op_rori, isa_pkg::op_srli: begin
				ctrl.alu_op = shift_op(opcode[1:0]);
				ctrl.imm_sel = pipe_pkg::imm_zext5;
				ctrl.dst = instr.i1_fmt.rd;
			end
			// Compare as rs - rt so the flags give the relation
			isa_pkg::op_seq, isa_pkg::op_slt, isa_pkg::op_sle: begin
				ctrl.inv_b = 1'b1;
				ctrl.cin = 1'b1;
				ctrl.set_op = pipe_pkg::set_op_t'(opcode[1:0]);
				ctrl.out_sel = isa_pkg::out_set_true;
			end
			isa_pkg::op_sco: begin
				ctrl.set_op = pipe_pkg::set_co;
				ctrl.out_sel = isa_pkg::out_set_true;
			end
			isa_pkg::op_btr: ctrl.out_sel = isa_pkg::out_bit_reverse;
			isa_pkg::op_lbi: begin
				ctrl.out_sel = isa_pkg::out_lbi;
				ctrl.dst = instr.i2_fmt.rs;
			end
			isa_pkg::op_slbi: begin
				ctrl.out_sel = isa_pkg::out_slbi;
				ctrl.dst = instr.i2_fmt.rs;
			end
			isa_pkg::op_nop: ctrl.reg_write = 1'b0;
			// HALT and every unsupported opcode
			default: begin
				ctrl.reg_write = 1'b0;
				ctrl.illegal = 1'b1;
			end
		endcase
	end

	always_comb begin
		dec_next.valid = instr_valid;
		dec_next.ctrl = ctrl;
		dec_next.rs = instr.r_fmt.rs;
		dec_next.rt = instr.r_fmt.rt;
		dec_next.rs_data = rd_data_a;
		dec_next.rt_data = rd_data_b;
		dec_next.imm5 = instr.i1_fmt.imm5;
		dec_next.imm8 = instr.i2_fmt.imm8;
	end

	always_ff @(posedge clk) begin
		dec_exe <= dec_next;
		if (rst) begin
			dec_exe.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire pipe_pkg::dec_exe_t dec_exe,
	input  wire pipe_pkg::wb_t      fwd,
	output pipe_pkg::exe_res_t      exe_res
);

	localparam int ext_w = isa_pkg::data_w - isa_pkg::imm5_w;

	isa_pkg::data_t     op_a;
	isa_pkg::data_t     rt_val;
	isa_pkg::data_t     op_b;
	isa_pkg::data_t     alu_y;
	logic               carry;
	logic               ofl;
	logic               zero;
	logic               neg;
	pipe_pkg::exe_res_t exe_next;

	// Result of the instruction just ahead overrides the stale register read
	assign op_a = (fwd.valid && fwd.idx == dec_exe.rs) ? fwd.data : dec_exe.rs_data;
	assign rt_val = (fwd.valid && fwd.idx == dec_exe.rt) ? fwd.data : dec_exe.rt_data;

	always_comb begin
		case (dec_exe.ctrl.imm_sel)
			pipe_pkg::imm_sext5: op_b = {{ext_w{dec_exe.imm5[isa_pkg::imm5_w-1]}}, dec_exe.imm5};
			pipe_pkg::imm_zext5: op_b = {{ext_w{1'b0}}, dec_exe.imm5};
			default:             op_b = rt_val;
		endcase
	end

	alu alu_i (
		.a     (op_a),
		.b     (op_b),
		.op    (dec_exe.ctrl.alu_op),
		.inv_a (dec_exe.ctrl.inv_a),
		.inv_b (dec_exe.ctrl.inv_b),
		.cin   (dec_exe.ctrl.cin),
		.y     (alu_y),
		.carry (carry),
		.ofl   (ofl),
		.zero  (zero),
		.neg   (neg)
	);

	always_comb begin
		exe_next.valid = dec_exe.valid;
		exe_next.ctrl = dec_exe.ctrl;
		exe_next.alu_y = alu_y;
		exe_next.carry = carry;
		exe_next.ofl = ofl;
		exe_next.zero = zero;
		exe_next.neg = neg;
		exe_next.op_a = op_a;
		exe_next.imm8 = dec_exe.imm8;
	end

	always_ff @(posedge clk) begin
		exe_res <= exe_next;
		if (rst) begin
			exe_res.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	localparam int data_w = 16;
	localparam int reg_idx_w = 3;
	localparam int num_regs = 1 << reg_idx_w;
	localparam int imm5_w = 5;
	localparam int imm8_w = 8;

	typedef logic [data_w-1:0] data_t;
	typedef logic [reg_idx_w-1:0] reg_idx_t;

	// Encodings not listed here decode as illegal
	typedef enum logic [4:0] {
		op_halt    = 5'b00000,
		op_nop     = 5'b00001,
		op_addi    = 5'b01000,
		op_subi    = 5'b01001,
		op_xori    = 5'b01010,
		op_andni   = 5'b01011,
		op_slbi    = 5'b10010,
		op_roli    = 5'b10100,
		op_slli    = 5'b10101,
		op_rori    = 5'b10110,
		op_srli    = 5'b10111,
		op_lbi     = 5'b11000,
		op_btr     = 5'b11001,
		op_shift_r = 5'b11010,
		op_alu_r   = 5'b11011,
		op_seq     = 5'b11100,
		op_slt     = 5'b11101,
		op_sle     = 5'b11110,
		op_sco     = 5'b11111
	} opcode_t;

	typedef logic [1:0] funct_t;

	// Arithmetic group and low bits of the immediate opcodes
	localparam funct_t funct_add  = 2'b00;
	localparam funct_t funct_sub  = 2'b01;
	localparam funct_t funct_xor  = 2'b10;
	localparam funct_t funct_andn = 2'b11;

	// Shift group
	localparam funct_t funct_rol = 2'b00;
	localparam funct_t funct_sll = 2'b01;
	localparam funct_t funct_ror = 2'b10;
	localparam funct_t funct_srl = 2'b11;

	typedef struct packed {
		opcode_t  opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		funct_t   funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_t           opcode;
		reg_idx_t          rs;
		reg_idx_t          rd;
		logic [imm5_w-1:0] imm5;
	} i1_fmt_t;

	typedef struct packed {
		opcode_t           opcode;
		reg_idx_t          rs;
		logic [imm8_w-1:0] imm8;
	} i2_fmt_t;

	typedef union packed {
		r_fmt_t  r_fmt;
		i1_fmt_t i1_fmt;
		i2_fmt_t i2_fmt;
	} instr_u;

	typedef enum logic [2:0] {
		out_alu,
		out_set_true,
		out_set_false,
		out_bit_reverse,
		out_lbi,
		out_slbi
	} out_sel_t;

endpackage

`default_nettype wire

// ==== source/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

	typedef enum logic [2:0] {
		alu_add,
		alu_xor,
		alu_andn,
		alu_rol,
		alu_sll,
		alu_ror,
		alu_srl
	} alu_op_t;

	// Source of operand B
	typedef enum logic [1:0] {
		imm_none,
		imm_sext5,
		imm_zext5
	} imm_sel_t;

	// Order matches the low opcode bits of SEQ, SLT, SLE, SCO
	typedef enum logic [1:0] {
		set_eq,
		set_lt,
		set_le,
		set_co
	} set_op_t;

	typedef struct packed {
		logic              reg_write;
		logic              illegal;
		alu_op_t           alu_op;
		logic              inv_a;
		logic              inv_b;
		logic              cin;
		imm_sel_t          imm_sel;
		set_op_t           set_op;
		isa_pkg::out_sel_t out_sel;
		isa_pkg::reg_idx_t dst;
	} ctrl_t;

	typedef struct packed {
		logic                       valid;
		ctrl_t                      ctrl;
		isa_pkg::reg_idx_t          rs;
		isa_pkg::reg_idx_t          rt;
		isa_pkg::data_t             rs_data;
		isa_pkg::data_t             rt_data;
		logic [isa_pkg::imm5_w-1:0] imm5;
		logic [isa_pkg::imm8_w-1:0] imm8;
	} dec_exe_t;

	typedef struct packed {
		logic                       valid;
		ctrl_t                      ctrl;
		isa_pkg::data_t             alu_y;
		logic                       carry;
		logic                       ofl;
		logic                       zero;
		logic                       neg;
		isa_pkg::data_t             op_a;
		logic [isa_pkg::imm8_w-1:0] imm8;
	} exe_res_t;

	typedef struct packed {
		logic              valid;
		isa_pkg::reg_idx_t idx;
		isa_pkg::data_t    data;
	} wb_t;

endpackage

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire isa_pkg::reg_idx_t rd_idx_a,
	input  wire isa_pkg::reg_idx_t rd_idx_b,
	output isa_pkg::data_t         rd_data_a,
	output isa_pkg::data_t         rd_data_b,
	input  wire pipe_pkg::wb_t     wr
);

	isa_pkg::data_t regs [isa_pkg::num_regs];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < isa_pkg::num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid) begin
			regs[wr.idx] <= wr.data;
		end
	end

	// Write-through bypass for a read of the register being written
	always_comb begin
		if (wr.valid && wr.idx == rd_idx_a) begin
			rd_data_a = wr.data;
		end else begin
			rd_data_a = regs[rd_idx_a];
		end

		if (wr.valid && wr.idx == rd_idx_b) begin
			rd_data_b = wr.data;
		end else begin
			rd_data_b = regs[rd_idx_b];
		end
	end

endmodule

`default_nettype wire

// ==== source/result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_stage (
	input  wire pipe_pkg::exe_res_t exe_res,
	output pipe_pkg::wb_t           wb,
	output logic                    err
);

	localparam int ext_w = isa_pkg::data_w - isa_pkg::imm8_w;

	logic              set_hit;
	logic              lt;
	isa_pkg::out_sel_t sel;
	isa_pkg::data_t    rev;
	isa_pkg::data_t    value;

	// Signed less-than of rs - rt
	assign lt = exe_res.neg ^ exe_res.ofl;

	always_comb begin
		case (exe_res.ctrl.set_op)
			pipe_pkg::set_eq: set_hit = exe_res.zero;
			pipe_pkg::set_lt: set_hit = lt;
			pipe_pkg::set_le: set_hit = exe_res.zero | lt;
			default:          set_hit = exe_res.carry;
		endcase
	end

	assign rev = {<<{exe_res.op_a}};

	always_comb begin
		sel = exe_res.ctrl.out_sel;
		// A set instruction whose condition fails writes zero
		if (sel == isa_pkg::out_set_true && !set_hit) begin
			sel = isa_pkg::out_set_false;
		end

		case (sel)
			isa_pkg::out_set_true:    value = isa_pkg::data_t'(1);
			isa_pkg::out_set_false:   value = '0;
			isa_pkg::out_bit_reverse: value = rev;
			isa_pkg::out_lbi:         value = {{ext_w{exe_res.imm8[isa_pkg::imm8_w-1]}}, exe_res.imm8};
			isa_pkg::out_slbi:        value = {exe_res.op_a[ext_w-1:0], exe_res.imm8};
			default:                  value = exe_res.alu_y;
		endcase
	end

	assign wb.valid = exe_res.valid & exe_res.ctrl.reg_write;
	assign wb.idx = exe_res.ctrl.dst;
	assign wb.data = value;

	assign err = exe_res.valid & exe_res.ctrl.illegal;

endmodule

`default_nettype wire

// ==== source/wisc_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module wisc_core (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire isa_pkg::instr_u instr,
	input  wire logic            instr_valid,
	output pipe_pkg::wb_t        wb,
	output logic                 err
);

	isa_pkg::reg_idx_t  rd_idx_a;
	isa_pkg::reg_idx_t  rd_idx_b;
	isa_pkg::data_t     rd_data_a;
	isa_pkg::data_t     rd_data_b;
	pipe_pkg::dec_exe_t dec_exe;
	pipe_pkg::exe_res_t exe_res;

	reg_file reg_file_i (
		.clk       (clk),
		.rst       (rst),
		.rd_idx_a  (rd_idx_a),
		.rd_idx_b  (rd_idx_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr        (wb)
	);

	decode_stage decode_stage_i (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.rd_idx_a    (rd_idx_a),
		.rd_idx_b    (rd_idx_b),
		.rd_data_a   (rd_data_a),
		.rd_data_b   (rd_data_b),
		.dec_exe     (dec_exe)
	);

	// Write-back feeds execute directly for back-to-back dependencies
	execute_stage execute_stage_i (
		.clk     (clk),
		.rst     (rst),
		.dec_exe (dec_exe),
		.fwd     (wb),
		.exe_res (exe_res)
	);

	result_stage result_stage_i (
		.exe_res (exe_res),
		.wb      (wb),
		.err     (err)
	);

endmodule

`default_nettype wire

// ==== verification/wisc_core_golden.txt ====
// Columns (hex): instruction, write flag, register index, value, err
// Registers start at zero; results are in program order
C112 1 1 0012 0  // lbi r1, 0x12
9134 1 1 1234 0  // slbi r1, 0x34
C280 1 2 FF80 0  // lbi r2, 0x80 (negative)
92F0 1 2 80F0 0  // slbi r2, 0xf0
D950 1 4 9324 0  // add r4 = r1 + r2
D955 1 5 6EBC 0  // sub r5 = r2 - r1
D95A 1 6 92C4 0  // xor r6 = r1 ^ r2
DA3F 1 7 80C0 0  // andn r7 = r2 & ~r1
419F 1 4 1233 0  // addi r4 = r1 + -1
49A5 1 5 EDD1 0  // subi r5 = 5 - r1
52DF 1 6 80EF 0  // xori r6 = r2 ^ 0x1f, zero extended
59F0 1 7 1224 0  // andni r7 = r1 & ~0x10
A281 1 4 01E1 0  // roli r4 = rol r2, 1
AEAF 1 5 8000 0  // slli r5 = r6 << 15
B1CF 1 6 2468 0  // rori r6 = ror r1, 15
BAE0 1 7 80F0 0  // srli r7 = r2 >> 0
C30F 1 3 000F 0  // lbi r3, 0x0f
D273 1 4 0001 0  // srl r4 = r2 >> r3
D374 1 5 8007 0  // rol r5 = rol r3, r3
D599 1 6 000E 0  // sll r6 = r5 << r4
D11E 1 7 1234 0  // ror r7 = ror r1, r0
E1F0 1 4 0001 0  // seq r4 = r1 == r7
EA34 1 5 0001 0  // slt r5 = r2 < r1
F158 1 6 0000 0  // sle r6 = r1 <= r2
FA5C 1 7 0001 0  // sco r7 = carry of r2 + r2
C90C 1 3 2C48 0  // btr r3 = reverse r1
F950 1 4 0000 0  // sco r4 = carry of r1 + r2
4121 1 1 1235 0  // addi r1 = r1 + 1
4121 1 1 1236 0  // addi r1 = r1 + 1, back to back
D928 1 2 246C 0  // add r2 = r1 + r1
D94E 1 3 365A 0  // xor r3 = r1 ^ r2
DA71 1 4 11EE 0  // sub r4 = r3 - r2
0000 0 0 0000 1  // halt
0BFC 0 0 0000 0  // nop
13FF 0 0 0000 1  // unused opcode
44A2 1 5 11F0 0  // addi r5 = r4 + 2
950A 1 5 F00A 0  // slbi r5, 0x0a

// ==== verification/wisc_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module wisc_core_tb;

	localparam int num_lines = 37;
	localparam int fields = 5;
	localparam int bubble_every = 5;
	localparam int max_cycles = num_lines + 20;

	// One expected strobe from the golden file
	typedef struct packed {
		logic          err;
		pipe_pkg::wb_t wb;
	} expect_t;

	logic            clk;
	logic            rst;
	isa_pkg::instr_u instr;
	logic            instr_valid;
	pipe_pkg::wb_t   wb;
	logic            err;

	isa_pkg::data_t golden_mem [num_lines*fields];
	expect_t        expect_q [$];
	int             value_errors;
	int             strobe_errors;
	int             cycle_count;

	wisc_core wisc_core_i (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.wb          (wb),
		.err         (err)
	);

	always #50 clk = ~clk;

	task automatic check_wb(input pipe_pkg::wb_t got, input pipe_pkg::wb_t want);
		if (got !== want) begin
			value_errors++;
			$display("ERROR at %0t: wb valid/idx/data is %0b/%0d/%h, expected %0b/%0d/%h",
				$time, got.valid, got.idx, got.data, want.valid, want.idx, want.data);
		end
	endtask

	task automatic check_err(input logic got, input logic want);
		if (got !== want) begin
			value_errors++;
			$display("ERROR at %0t: err is %0b, expected %0b", $time, got, want);
		end
	endtask

	// Lines that expect neither a write nor an err leave nothing to compare
	task automatic queue_expect(input int line);
		expect_t e;
		int      base;
		base = line * fields;
		e.wb.valid = golden_mem[base+1][0];
		e.wb.idx = golden_mem[base+2][2:0];
		e.wb.data = golden_mem[base+3];
		e.err = golden_mem[base+4][0];
		if (e.wb.valid || e.err) begin
			expect_q.push_back(e);
		end
	endtask

	task automatic apply_instr(input isa_pkg::data_t word, input logic valid);
		instr = word;
		instr_valid = valid;
		@(negedge clk);
	endtask

	task automatic print_summary();
		$display("Summary: %0d wrong values, %0d unexpected strobes, %0d results missing",
			value_errors, strobe_errors, expect_q.size());
	endtask

	// Outputs change at the rising edge, so the falling edge sees them settled
	always @(negedge clk) begin
		expect_t want;
		if (!rst && (wb.valid || err)) begin
			if (expect_q.size() == 0) begin
				strobe_errors++;
				$display("Unexpected strobe at %0t with no result left to compare", $time);
			end else begin
				want = expect_q.pop_front();
				check_err(err, want.err);
				if (want.wb.valid || wb.valid) begin
					check_wb(wb, want.wb);
				end
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < max_cycles) begin
			@(posedge clk);
			if (!rst) begin
				cycle_count++;
			end
		end
		$display("Timeout after %0d cycles, %0d results never arrived",
			cycle_count, expect_q.size());
		print_summary();
		$display("Done: errors found");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		instr = '0;
		instr_valid = 1'b0;
		value_errors = 0;
		strobe_errors = 0;
		$readmemh("verification/wisc_core_golden.txt", golden_mem);

		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (int i = 0; i < num_lines; i++) begin
			queue_expect(i);
			apply_instr(golden_mem[i*fields], 1'b1);
			// Bubble with a junk word that must not write
			if (i % bubble_every == bubble_every - 1 && i != num_lines - 1) begin
				apply_instr(16'hffff, 1'b0);
			end
		end
		apply_instr(16'hffff, 1'b0);

		while (expect_q.size() != 0) begin
			@(negedge clk);
		end
		// Room for a stray strobe after the last result
		repeat (3) @(negedge clk);

		print_summary();
		if (value_errors == 0 && strobe_errors == 0 && expect_q.size() == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== wisc_core.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/reg_file.sv
source/decode_stage.sv
source/alu.sv
source/execute_stage.sv
source/result_stage.sv
source/wisc_core.sv
verification/wisc_core_tb.sv
